// ==== fetch_chroma_pkg.sv ====
/*
 * widths, geometry constants and state encodings
 * shared by the chroma reference fetch unit
 */
`default_nettype none

package fetch_chroma_pkg;

  // pixel format
  localparam int BIT_DEPTH   = 8;
  localparam int PIX_PER_ROW = 8;          // pixels per row word
  localparam int MB_LEN      = 8;          // mb coordinate width
  localparam int SW_W_LEN    = 6;          // search window x width
  localparam int SW_H_LEN    = 5;          // search window y width

  // ************************************************************
  // bank geometry
  // ************************************************************
  localparam int NUM_SLOTS     = 6;        // columns held in each ring
  localparam int ROWS_PER_SLOT = 24;       // three mbs per column
  localparam int ROWS_PER_MB   = 8;        // rows per mb per plane
  localparam int BEATS_PER_MB  = 16;       // 8 cb + 8 cr beats
  localparam int RAM_DEPTH     = NUM_SLOTS * ROWS_PER_SLOT;

  typedef logic [BIT_DEPTH-1:0]             pix_t;
  typedef logic [PIX_PER_ROW*BIT_DEPTH-1:0] pix_row_t;   // pixel 0 in low byte
  typedef logic [MB_LEN-1:0]                mb_coord_t;
  typedef logic [SW_W_LEN-1:0]              sw_x_t;
  typedef logic [SW_H_LEN-1:0]              sw_y_t;
  typedef logic [$clog2(NUM_SLOTS)-1:0]     slot_t;
  typedef logic [$clog2(RAM_DEPTH)-1:0]     ram_addr_t;

  // strip walk through the picture rows
  typedef enum logic [2:0] {
    idle, load_top, load_mid, load_bottom, load_none
  } strip_state_t;

  typedef enum logic {ext_wait, ext_load} ext_state_t;

  typedef enum logic [1:0] {bnd_none, bnd_left, bnd_right} boundary_t;

endpackage

`default_nettype wire

// ==== chroma_load_ctrl.sv ====
/*
 * strip controller: walks the picture rows per start,
 * works out base, extent and write base of each strip load
 * and answers every start with one done pulse
 */
`timescale 1ns/1ns
`default_nettype none

module chroma_load_ctrl
  import fetch_chroma_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             start_i,        // one cycle pulse per mb
  input  wire mb_coord_t  mb_x_i,
  input  wire mb_coord_t  mb_y_i,
  input  wire mb_coord_t  total_mb_x_i,   // largest x index
  input  wire mb_coord_t  total_mb_y_i,   // largest y index
  input  wire             strip_done_i,   // from loader, last ext done
  output logic            load_go_o,
  output mb_coord_t       load_x_base_o,
  output mb_coord_t       load_y_base_o,
  output logic [1:0]      load_x_last_o,  // columns - 1
  output logic [1:0]      load_y_last_o,  // rows - 1
  output logic            write_base_o,   // top row skips slot band 0
  output logic            done_o
);

  strip_state_t state_r;
  strip_state_t state_nxt;
  strip_state_t state_eff;   // state the current start is served in
  logic         row_end;     // start is last mb of its row
  logic         first_mb;    // picture's first start

  assign row_end   = (mb_x_i == total_mb_x_i);
  assign first_mb  = (mb_x_i == '0) && (mb_y_i == '0);
  assign state_eff = (state_r == idle) ? load_top : state_r;  // idle start loads top

  // ************************************************************
  // strip fsm
  // ************************************************************
  always_comb begin
    state_nxt = state_r;
    if (start_i) begin
      case (state_eff)
        load_top:    state_nxt = row_end ? load_mid : load_top;
        load_mid: begin
          if (row_end && (mb_y_i == total_mb_y_i - 8'd1))
            state_nxt = load_bottom;                // last interior row done
          else
            state_nxt = load_mid;
        end
        load_bottom: state_nxt = row_end ? load_none : load_bottom;
        default:     state_nxt = idle;              // load_none start
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r   <= idle;
      load_go_o <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      state_r   <= state_nxt;
      load_go_o <= start_i && (state_eff != load_none);
      // load_none has nothing to fetch, report right away
      done_o    <= strip_done_i || (start_i && (state_eff == load_none));
    end
  end

  // ************************************************************
  // strip geometry, captured on start
  // ************************************************************
  always_ff @(posedge clk) begin
    if (start_i) begin
      case (state_eff)
        load_top: begin
          load_x_base_o <= first_mb ? '0 : mb_x_i + 8'd1;
          load_y_base_o <= '0;
          load_x_last_o <= first_mb ? 2'd1 : 2'd0;   // 2x2 on first start
          load_y_last_o <= 2'd1;                     // rows 0 and 1
          write_base_o  <= 1'b1;                     // no row above
        end
        load_mid, load_bottom: begin
          // row end wraps to column 0 of the next row band
          load_x_base_o <= row_end ? '0 : mb_x_i + 8'd1;
          load_y_base_o <= row_end ? mb_y_i : mb_y_i - 8'd1;
          load_x_last_o <= 2'd0;
          load_y_last_o <= (state_eff == load_mid) ? 2'd2 : 2'd1;
          write_base_o  <= 1'b0;
        end
        default: ;                                   // nothing loaded
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== chroma_ext_loader.sv ====
/*
 * external loader: one memory request per mb of a strip,
 * x/y and beat counters, ring write slot, bank write address
 * and cb/cr write enables
 */
`timescale 1ns/1ns
`default_nettype none

module chroma_ext_loader
  import fetch_chroma_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             load_go_i,
  input  wire mb_coord_t  load_x_base_i,
  input  wire mb_coord_t  load_y_base_i,
  input  wire [1:0]       load_x_last_i,
  input  wire [1:0]       load_y_last_i,
  input  wire             write_base_i,
  input  wire             ext_done_i,
  input  wire             ext_data_v_i,
  output logic            ext_req_o,
  output mb_coord_t       ext_mb_x_o,
  output mb_coord_t       ext_mb_y_o,
  output logic            strip_done_o,
  output ram_addr_t       wr_addr_o,
  output logic            wr_en_cb_o,
  output logic            wr_en_cr_o
);

  ext_state_t                      state_r;
  ext_state_t                      state_nxt;
  logic                            strip_act_r;   // strip still has mbs to fetch
  logic [1:0]                      x_cnt_r;
  logic [1:0]                      y_cnt_r;       // y runs fastest
  logic [$clog2(BEATS_PER_MB)-1:0] beat_cnt_r;
  slot_t                           wr_slot_r;     // ring column being filled
  logic                            mb_done;
  logic                            col_done;
  logic                            strip_last;

  assign mb_done      = (state_r == ext_load) && ext_done_i;
  assign col_done     = mb_done && (y_cnt_r == load_y_last_i);
  assign strip_last   = col_done && (x_cnt_r == load_x_last_i);
  assign strip_done_o = strip_last;

  // ************************************************************
  // request fsm
  // ************************************************************
  always_comb begin
    case (state_r)
      ext_wait: state_nxt = strip_act_r ? ext_load : ext_wait;
      ext_load: state_nxt = ext_done_i ? ext_wait : ext_load;
      default:  state_nxt = ext_wait;
    endcase
  end

  assign ext_req_o  = (state_r == ext_load);  // drops the cycle after done
  assign ext_mb_x_o = load_x_base_i + mb_coord_t'(x_cnt_r);
  assign ext_mb_y_o = load_y_base_i + mb_coord_t'(y_cnt_r);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r     <= ext_wait;
      strip_act_r <= 1'b0;
      x_cnt_r     <= 2'd0;
      y_cnt_r     <= 2'd0;
      wr_slot_r   <= '0;
    end else begin
      state_r <= state_nxt;
      if (strip_last)
        strip_act_r <= 1'b0;
      else if (load_go_i)
        strip_act_r <= 1'b1;
      if (mb_done)
        y_cnt_r <= (y_cnt_r == load_y_last_i) ? 2'd0 : y_cnt_r + 2'd1;
      if (col_done) begin
        x_cnt_r   <= (x_cnt_r == load_x_last_i) ? 2'd0 : x_cnt_r + 2'd1;
        // next column lands in the next slot, mod 6
        wr_slot_r <= (wr_slot_r == slot_t'(NUM_SLOTS - 1)) ? '0 : wr_slot_r + 1'b1;
      end
    end
  end

  // beat counter, restarts for every mb
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      beat_cnt_r <= '0;
    else if (state_r == ext_wait)
      beat_cnt_r <= '0;
    else if (ext_data_v_i)
      beat_cnt_r <= beat_cnt_r + 1'b1;
  end

  // ************************************************************
  // bank write side
  // ************************************************************
  // beat bit 2 picks plane, bits 3 and 1..0 pick row within mb
  assign wr_addr_o = ram_addr_t'(wr_slot_r) * ram_addr_t'(ROWS_PER_SLOT)
                   + ram_addr_t'(y_cnt_r + 2'(write_base_i)) * ram_addr_t'(ROWS_PER_MB)
                   + ram_addr_t'({beat_cnt_r[3], beat_cnt_r[1:0]});

  assign wr_en_cb_o = (state_r == ext_load) && ext_data_v_i && !beat_cnt_r[2];
  assign wr_en_cr_o = (state_r == ext_load) && ext_data_v_i &&  beat_cnt_r[2];

endmodule

`default_nettype wire

// ==== chroma_ref_ram.sv ====
/*
 * one reference bank, 144 rows of 64 bits,
 * separate write and registered read ports
 */
`timescale 1ns/1ns
`default_nettype none

module chroma_ref_ram
  import fetch_chroma_pkg::*;
(
  input  wire             clk,
  input  wire             wr_en_i,
  input  wire ram_addr_t  wr_addr_i,
  input  wire pix_row_t   wr_data_i,
  input  wire             rd_en_i,
  input  wire ram_addr_t  rd_addr_i,
  output pix_row_t        rd_data_o     // valid one cycle after rd_en_i
);

  pix_row_t mem [RAM_DEPTH];           // 6 slots x 24 rows

  always_ff @(posedge clk) begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
  end

  // read data holds between reads
  always_ff @(posedge clk) begin
    if (rd_en_i)
      rd_data_o <= mem[rd_addr_i];
  end

endmodule

`default_nettype wire

// ==== chroma_reader.sv ====
/*
 * motion compensation read side: read slot pointer,
 * search window to bank address mapping, picture edge
 * clamping and edge pixel padding of the output row
 */
`timescale 1ns/1ns
`default_nettype none

module chroma_reader
  import fetch_chroma_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             rd_en_i,
  input  wire             rd_crcb_i,      // 0 cb, 1 cr
  input  wire             rd_done_i,      // mc finished with current mb
  input  wire mb_coord_t  rd_mb_x_i,
  input  wire mb_coord_t  rd_mb_y_i,
  input  wire sw_x_t      sw_x_i,
  input  wire sw_y_t      sw_y_i,
  input  wire mb_coord_t  total_mb_x_i,
  input  wire mb_coord_t  total_mb_y_i,
  input  wire pix_row_t   cb_data_i,
  input  wire pix_row_t   cr_data_i,
  output logic            rd_en_cb_o,
  output logic            rd_en_cr_o,
  output ram_addr_t       rd_addr_o,
  output logic            rd_ack_o,
  output pix_row_t        rd_data_o
);

  slot_t      rd_slot_r;   // slot of the current mb column
  logic [2:0] x_off;       // column offset, two's complement -2..2
  logic [2:0] col_off;     // offset after edge clamp
  boundary_t  bnd;
  boundary_t  bnd_r;       // aligned with bank read data
  logic [1:0] band;        // mb row within the slot
  logic [2:0] line;        // row within the mb
  logic [3:0] slot_sum;
  slot_t      slot_rd;
  logic       crcb_r;
  pix_row_t   row_sel;
  pix_t       edge_pix;

  // ************************************************************
  // column offset from sw_x bits 5..3
  // ************************************************************
  always_comb begin
    if (sw_x_i[SW_W_LEN-1])
      x_off = 3'b110;                                  // -2
    else if (sw_x_i[SW_W_LEN-2 -: 2] == 2'b00)
      x_off = 3'b111;                                  // -1
    else
      x_off = {1'b0, sw_x_i[SW_W_LEN-2 -: 2]} - 3'd1;  // 0, 1, 2
  end

  // edge clamp, columns beyond the picture were never loaded
  always_comb begin
    col_off = x_off;
    bnd     = bnd_none;
    if ((rd_mb_x_i == '0) && x_off[2]) begin
      col_off = 3'd0;
      bnd     = bnd_left;
    end else if ((rd_mb_x_i == 8'd1) && (x_off == 3'b110)) begin
      col_off = 3'b111;                                // -2 clamps to -1
      bnd     = bnd_left;
    end else if ((rd_mb_x_i == total_mb_x_i) && !x_off[2] && (x_off != 3'd0)) begin
      col_off = 3'd0;
      bnd     = bnd_right;
    end else if ((rd_mb_x_i == total_mb_x_i - 8'd1) && (x_off == 3'd2)) begin
      col_off = 3'd1;
      bnd     = bnd_right;
    end
  end

  // top and bottom rows clamp to the nearest valid line
  always_comb begin
    band = sw_y_i[SW_H_LEN-1 -: 2];
    line = sw_y_i[SW_H_LEN-3:0];
    if ((rd_mb_y_i == '0) && (band == 2'd0)) begin
      band = 2'd1;
      line = 3'd0;
    end else if ((rd_mb_y_i == total_mb_y_i) && (band == 2'd2)) begin
      band = 2'd1;
      line = 3'd7;
    end
  end

  // ************************************************************
  // slot and address
  // ************************************************************
  assign slot_sum = {1'b0, rd_slot_r} + {col_off[2], col_off};  // range -2..7

  always_comb begin
    if (slot_sum[3])
      slot_rd = slot_t'(slot_sum + 4'(NUM_SLOTS));   // wrap below 0
    else if (slot_sum >= 4'(NUM_SLOTS))
      slot_rd = slot_t'(slot_sum - 4'(NUM_SLOTS));   // wrap above 5
    else
      slot_rd = slot_t'(slot_sum);
  end

  assign rd_addr_o = ram_addr_t'(slot_rd) * ram_addr_t'(ROWS_PER_SLOT)
                   + ram_addr_t'(band) * ram_addr_t'(ROWS_PER_MB)
                   + ram_addr_t'(line);

  assign rd_en_cb_o = rd_en_i && !rd_crcb_i;
  assign rd_en_cr_o = rd_en_i &&  rd_crcb_i;
  assign rd_ack_o   = rd_en_i;                 // same cycle ack

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_slot_r <= '0;
      bnd_r     <= bnd_none;
      crcb_r    <= 1'b0;
    end else begin
      if (rd_done_i)
        rd_slot_r <= (rd_slot_r == slot_t'(NUM_SLOTS - 1)) ? '0 : rd_slot_r + 1'b1;
      bnd_r  <= bnd;
      crcb_r <= rd_crcb_i;                     // matches bank read latency
    end
  end

  // output row, edge pixel repeated on a boundary
  assign row_sel  = crcb_r ? cr_data_i : cb_data_i;
  assign edge_pix = (bnd_r == bnd_left) ? row_sel[0 +: BIT_DEPTH]
                                        : row_sel[(PIX_PER_ROW-1)*BIT_DEPTH +: BIT_DEPTH];
  assign rd_data_o = (bnd_r == bnd_none) ? row_sel : {PIX_PER_ROW{edge_pix}};

endmodule

`default_nettype wire

// ==== fetch_chroma.sv ====
/*
 * chroma reference fetch top: strip controller, external
 * loader, cb and cr banks and the mc read path
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_chroma
  import fetch_chroma_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  // system
  input  wire             start_i,
  input  wire mb_coord_t  mb_x_i,
  input  wire mb_coord_t  mb_y_i,
  input  wire mb_coord_t  total_mb_x_i,
  input  wire mb_coord_t  total_mb_y_i,
  output logic            done_o,
  // external memory
  output logic            ext_req_o,
  output mb_coord_t       ext_mb_x_o,
  output mb_coord_t       ext_mb_y_o,
  input  wire             ext_done_i,
  input  wire             ext_data_v_i,
  input  wire pix_row_t   ext_data_i,
  // mc read
  input  wire             rd_en_i,
  input  wire             rd_crcb_i,
  input  wire             rd_done_i,
  input  wire mb_coord_t  rd_mb_x_i,
  input  wire mb_coord_t  rd_mb_y_i,
  input  wire sw_x_t      sw_x_i,
  input  wire sw_y_t      sw_y_i,
  output logic            rd_ack_o,
  output pix_row_t        rd_data_o
);

  logic       load_go;
  mb_coord_t  load_x_base;
  mb_coord_t  load_y_base;
  logic [1:0] load_x_last;
  logic [1:0] load_y_last;
  logic       write_base;
  logic       strip_done;
  ram_addr_t  wr_addr;
  logic       wr_en_cb;
  logic       wr_en_cr;
  logic       rd_en_cb;
  logic       rd_en_cr;
  ram_addr_t  rd_addr;
  pix_row_t   cb_data;
  pix_row_t   cr_data;

  chroma_load_ctrl ctrl_i (
    .clk, .rst_n, .start_i, .mb_x_i, .mb_y_i, .total_mb_x_i, .total_mb_y_i,
    .strip_done_i  (strip_done),
    .load_go_o     (load_go),
    .load_x_base_o (load_x_base),
    .load_y_base_o (load_y_base),
    .load_x_last_o (load_x_last),
    .load_y_last_o (load_y_last),
    .write_base_o  (write_base),
    .done_o
  );

  chroma_ext_loader loader_i (
    .clk, .rst_n,
    .load_go_i     (load_go),
    .load_x_base_i (load_x_base),
    .load_y_base_i (load_y_base),
    .load_x_last_i (load_x_last),
    .load_y_last_i (load_y_last),
    .write_base_i  (write_base),
    .ext_done_i, .ext_data_v_i, .ext_req_o, .ext_mb_x_o, .ext_mb_y_o,
    .strip_done_o  (strip_done),
    .wr_addr_o     (wr_addr),
    .wr_en_cb_o    (wr_en_cb),
    .wr_en_cr_o    (wr_en_cr)
  );

  // cb bank
  chroma_ref_ram cb_ram_i (
    .clk, .wr_en_i (wr_en_cb), .wr_addr_i (wr_addr), .wr_data_i (ext_data_i),
    .rd_en_i (rd_en_cb), .rd_addr_i (rd_addr), .rd_data_o (cb_data)
  );

  // cr bank
  chroma_ref_ram cr_ram_i (
    .clk, .wr_en_i (wr_en_cr), .wr_addr_i (wr_addr), .wr_data_i (ext_data_i),
    .rd_en_i (rd_en_cr), .rd_addr_i (rd_addr), .rd_data_o (cr_data)
  );

  chroma_reader reader_i (
    .clk, .rst_n, .rd_en_i, .rd_crcb_i, .rd_done_i, .rd_mb_x_i, .rd_mb_y_i,
    .sw_x_i, .sw_y_i, .total_mb_x_i, .total_mb_y_i,
    .cb_data_i  (cb_data),
    .cr_data_i  (cr_data),
    .rd_en_cb_o (rd_en_cb),
    .rd_en_cr_o (rd_en_cr),
    .rd_addr_o  (rd_addr),
    .rd_ack_o, .rd_data_o
  );

endmodule

`default_nettype wire

// ==== tb_fetch_chroma.sv ====
/*
 * testbench for the chroma fetch unit
 * external memory model with random beat gaps, start table with
 * expected requests, read table checked against a ring model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_chroma
  import fetch_chroma_pkg::*;
();

  localparam int TIMEOUT_CYC = 2000;   // per start
  localparam int N_STARTS    = 10;
  localparam int N_READS     = 13;
  localparam int TOT_X       = 2;      // 3x3 picture
  localparam int TOT_Y       = 2;

  logic      clk;
  logic      rst_n;
  logic      start_i;
  mb_coord_t mb_x_i;
  mb_coord_t mb_y_i;
  mb_coord_t total_mb_x_i;
  mb_coord_t total_mb_y_i;
  logic      done_o;
  logic      ext_req_o;
  mb_coord_t ext_mb_x_o;
  mb_coord_t ext_mb_y_o;
  logic      ext_done_i;
  logic      ext_data_v_i;
  pix_row_t  ext_data_i;
  logic      rd_en_i;
  logic      rd_crcb_i;
  logic      rd_done_i;
  mb_coord_t rd_mb_x_i;
  mb_coord_t rd_mb_y_i;
  sw_x_t     sw_x_i;
  sw_y_t     sw_y_i;
  logic      rd_ack_o;
  pix_row_t  rd_data_o;

  int          val_errs = 0;
  int          to_errs  = 0;
  logic [31:0] lcg_state;
  int          ring_x [NUM_SLOTS][3];   // mb held by slot and band
  int          ring_y [NUM_SLOTS][3];
  int          wr_slot_m;
  int          rd_slot_m;

  // ************************************************************
  // stimulus tables
  // ************************************************************
  // requests packed one byte each, {x, y} nibbles, first in low byte
  mb_coord_t   st_x   [N_STARTS] = '{8'd0, 8'd1, 8'd2, 8'd0, 8'd1, 8'd2, 8'd0, 8'd1, 8'd2, 8'd0};
  mb_coord_t   st_y   [N_STARTS] = '{8'd0, 8'd0, 8'd0, 8'd1, 8'd1, 8'd1, 8'd2, 8'd2, 8'd2, 8'd0};
  int          st_n   [N_STARTS] = '{4, 2, 2, 3, 3, 3, 2, 2, 2, 0};   // last start loads nothing
  logic [31:0] st_req [N_STARTS] = '{32'h11100100, 32'h00002120, 32'h00003130,
                                     32'h00121110, 32'h00222120, 32'h00030201,
                                     32'h00001211, 32'h00002221, 32'h00000302, 32'h0};

  // read cases, sw_x top octal digit is the column offset code
  logic      rc_cr   [N_READS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
                                   1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  mb_coord_t rc_mx   [N_READS] = '{8'd1, 8'd1, 8'd1, 8'd1, 8'd0, 8'd2, 8'd1,
                                   8'd1, 8'd1, 8'd1, 8'd2, 8'd1, 8'd1};
  mb_coord_t rc_my   [N_READS] = '{8'd1, 8'd1, 8'd1, 8'd1, 8'd1, 8'd1, 8'd1,
                                   8'd0, 8'd2, 8'd1, 8'd1, 8'd1, 8'd1};
  sw_x_t     rc_swx  [N_READS] = '{6'o20, 6'o10, 6'o00, 6'o40, 6'o04, 6'o30, 6'o30,
                                   6'o10, 6'o10, 6'o20, 6'o40, 6'o20, 6'o00};
  sw_y_t     rc_swy  [N_READS] = '{5'd11, 5'd5, 5'd22, 5'd12, 5'd9, 5'd14, 5'd3,
                                   5'd4, 5'd17, 5'd10, 5'd7, 5'd15, 5'd20};
  logic      rc_done [N_READS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                                   1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

  fetch_chroma fetch_chroma_i (.*);

  always #5 clk = ~clk;

  // pixel tagged with its origin, index spread so edge pixels differ
  function automatic pix_t pixel_of(int mbx, int mby, logic cr, int row, int idx);
    pix_t base;
    base = {2'(mbx), 2'(mby), cr, 3'(row)};
    return base ^ pix_t'(idx * 53);
  endfunction

  function automatic pix_row_t make_row(int mbx, int mby, logic cr, int row);
    pix_row_t r;
    int       p;
    for (p = 0; p < PIX_PER_ROW; p++)
      r[p*BIT_DEPTH +: BIT_DEPTH] = pixel_of(mbx, mby, cr, row, p);
    return r;
  endfunction

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // row a read case should return, from offset, clamp and ring rules
  function automatic pix_row_t expected_row(int i);
    int       off;
    int       bnd;     // 0 none, 1 left, 2 right
    int       band;
    int       line;
    int       slot;
    pix_row_t r;
    if (rc_swx[i][5])
      off = -2;
    else if (rc_swx[i][4:3] == 2'd0)
      off = -1;
    else
      off = int'(rc_swx[i][4:3]) - 1;
    bnd = 0;
    if (rc_mx[i] == 8'd0 && off < 0) begin
      off = 0;
      bnd = 1;
    end else if (rc_mx[i] == 8'd1 && off == -2) begin
      off = -1;
      bnd = 1;
    end else if (int'(rc_mx[i]) == TOT_X && off > 0) begin
      off = 0;
      bnd = 2;
    end else if (int'(rc_mx[i]) == TOT_X - 1 && off == 2) begin
      off = 1;
      bnd = 2;
    end
    band = int'(rc_swy[i][4:3]);
    line = int'(rc_swy[i][2:0]);
    if (rc_my[i] == 8'd0 && band == 0) begin
      band = 1;                                   // top row, first line
      line = 0;
    end else if (int'(rc_my[i]) == TOT_Y && band == 2) begin
      band = 1;                                   // bottom row, last line
      line = 7;
    end
    slot = (rd_slot_m + off + NUM_SLOTS) % NUM_SLOTS;
    r = make_row(ring_x[slot][band], ring_y[slot][band], rc_cr[i], line);
    if (bnd == 1)
      r = {PIX_PER_ROW{r[BIT_DEPTH-1:0]}};
    else if (bnd == 2)
      r = {PIX_PER_ROW{r[PIX_PER_ROW*BIT_DEPTH-1 -: BIT_DEPTH]}};
    return r;
  endfunction

  // ring model, one slot per column, top row strips start at band 1
  task automatic update_ring(int s);
    int j;
    int x;
    int y;
    int first_y;
    int wb;
    wb = (st_y[s] == 8'd0) ? 1 : 0;
    first_y = 0;
    for (j = 0; j < st_n[s]; j++) begin
      x = int'(st_req[s][8*j+4 +: 4]);
      y = int'(st_req[s][8*j +: 4]);
      if (j == 0) begin
        first_y = y;
      end else if (x != int'(st_req[s][8*j-4 +: 4])) begin
        wr_slot_m = (wr_slot_m + 1) % NUM_SLOTS;  // new column
        first_y = y;
      end
      ring_x[wr_slot_m][y - first_y + wb] = x;
      ring_y[wr_slot_m][y - first_y + wb] = y;
    end
    if (st_n[s] > 0)
      wr_slot_m = (wr_slot_m + 1) % NUM_SLOTS;
  endtask

  // ************************************************************
  // compare tasks
  // ************************************************************
  task automatic check_mb(input mb_coord_t got, input mb_coord_t exp, input string msg);
    if (got !== exp) begin
      val_errs++;
      $display("[FAIL] %0t: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_row(input pix_row_t got, input pix_row_t exp, input string msg);
    if (got !== exp) begin
      val_errs++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      val_errs++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // external memory answer to one request, beats in fixed order
  task automatic serve_mb(int s, int n);
    int        k;
    int        gap;
    mb_coord_t mbx;
    mb_coord_t mby;
    mbx = ext_mb_x_o;
    mby = ext_mb_y_o;
    if (n < st_n[s]) begin
      check_mb(mbx, mb_coord_t'(st_req[s][8*n+4 +: 4]), $sformatf("start %0d req %0d x", s, n));
      check_mb(mby, mb_coord_t'(st_req[s][8*n +: 4]), $sformatf("start %0d req %0d y", s, n));
    end else begin
      val_errs++;
      $display("[FAIL] %0t: start %0d made an extra request", $time, s);
    end
    for (k = 0; k < BEATS_PER_MB; k++) begin
      lcg_state = lcg_next(lcg_state);
      gap = int'(lcg_state[17:16]) % 3;          // 0..2 idle cycles
      repeat (gap) begin
        ext_data_v_i <= 1'b0;
        @(posedge clk);
      end
      ext_data_i   <= make_row(int'(mbx), int'(mby), k[2], (k / 8) * 4 + k % 4);
      ext_data_v_i <= 1'b1;
      @(posedge clk);
    end
    ext_data_v_i <= 1'b0;
    ext_done_i   <= 1'b1;
    @(posedge clk);
    ext_done_i   <= 1'b0;
  endtask

  task automatic run_start(int s);
    int cyc;
    int n;
    int dones;
    int tail;
    cyc   = 0;
    n     = 0;
    dones = 0;
    tail  = 0;
    @(posedge clk);
    start_i <= 1'b1;
    mb_x_i  <= st_x[s];
    mb_y_i  <= st_y[s];
    @(posedge clk);
    start_i <= 1'b0;
    // serve requests until done, then watch a few quiet cycles
    while (tail < 4 && n < 6 && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      cyc++;
      if (dones > 0) begin
        tail++;
        check_bit(ext_req_o, 1'b0, $sformatf("start %0d ext_req_o after done", s));
      end
      if (done_o) begin
        dones++;
      end else if (ext_req_o && dones == 0) begin
        serve_mb(s, n);
        n++;
      end
    end
    if (cyc >= TIMEOUT_CYC) begin
      to_errs++;
      $display("timeout: no done_o within %0d cycles after start %0d", TIMEOUT_CYC, s);
    end else begin
      check_bit(n == st_n[s], 1'b1, $sformatf("start %0d request count", s));
      check_bit(dones == 1, 1'b1, $sformatf("start %0d single done_o pulse", s));
    end
    update_ring(s);
  endtask

  task automatic run_read(int i);
    pix_row_t exp_row;
    if (rc_done[i]) begin
      @(posedge clk);
      rd_done_i <= 1'b1;
      @(posedge clk);
      rd_done_i <= 1'b0;
      rd_slot_m = (rd_slot_m + 1) % NUM_SLOTS;
    end
    exp_row = expected_row(i);
    @(posedge clk);
    rd_en_i   <= 1'b1;
    rd_crcb_i <= rc_cr[i];
    rd_mb_x_i <= rc_mx[i];
    rd_mb_y_i <= rc_my[i];
    sw_x_i    <= rc_swx[i];
    sw_y_i    <= rc_swy[i];
    @(posedge clk);
    check_bit(rd_ack_o, 1'b1, $sformatf("read %0d rd_ack_o with rd_en_i", i));
    rd_en_i   <= 1'b0;
    // inputs move on, the row must come from the registered read
    rd_crcb_i <= !rc_cr[i];
    sw_x_i    <= ~rc_swx[i];
    sw_y_i    <= ~rc_swy[i];
    @(posedge clk);                               // data cycle
    check_bit(rd_ack_o, 1'b0, $sformatf("read %0d rd_ack_o after rd_en_i", i));
    check_row(rd_data_o, exp_row, $sformatf("read %0d data", i));
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************
  initial begin
    int i;
    int b;
    clk           = 1'b0;
    rst_n        <= 1'b0;
    start_i      <= 1'b0;
    mb_x_i       <= '0;
    mb_y_i       <= '0;
    total_mb_x_i <= mb_coord_t'(TOT_X);
    total_mb_y_i <= mb_coord_t'(TOT_Y);
    ext_done_i   <= 1'b0;
    ext_data_v_i <= 1'b0;
    ext_data_i   <= '0;
    rd_en_i      <= 1'b0;
    rd_crcb_i    <= 1'b0;
    rd_done_i    <= 1'b0;
    rd_mb_x_i    <= '0;
    rd_mb_y_i    <= '0;
    sw_x_i       <= '0;
    sw_y_i       <= '0;
    lcg_state = 32'd60;
    wr_slot_m = 0;
    rd_slot_m = 0;
    for (i = 0; i < NUM_SLOTS; i++) begin
      for (b = 0; b < 3; b++) begin
        ring_x[i][b] = -1;
        ring_y[i][b] = -1;
      end
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) begin                              // quiet until first start
      @(posedge clk);
      check_bit(done_o, 1'b0, "done_o before first start");
      check_bit(ext_req_o, 1'b0, "ext_req_o before first start");
      check_bit(rd_ack_o, 1'b0, "rd_ack_o while idle");
    end
    for (i = 0; i < N_STARTS && to_errs == 0; i++)
      run_start(i);
    if (to_errs == 0) begin
      for (i = 0; i < N_READS; i++)
        run_read(i);
    end
    $display("errors: %0d wrong values, %0d timeouts", val_errs, to_errs);
    if (val_errs == 0 && to_errs == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_chroma.f ====
fetch_chroma_pkg.sv
chroma_load_ctrl.sv
chroma_ext_loader.sv
chroma_ref_ram.sv
chroma_reader.sv
fetch_chroma.sv
tb_fetch_chroma.sv

// ==== Makefile ====
# Verilator lint and simulation of the chroma fetch unit

VERILATOR ?= verilator
FILELIST  ?= fetch_chroma.f
RTL_TOP   ?= fetch_chroma
TB_TOP    ?= tb_fetch_chroma
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
